// File: ls_pkg.sv
package ls_pkg;

    localparam int XLEN      = 32;
    localparam int INST_LEN  = 32;
    localparam int RAM_WORDS = 256;

    localparam logic [XLEN-1:0] MCAUSE_LS_TRAP = 32'd5; // Load access fault.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Instruction fields
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [4:0] {
        OP_LOAD   = 5'b00000,
        OP_ALUI   = 5'b00100,
        OP_STORE  = 5'b01000,
        OP_ALU    = 5'b01100,
        OP_SYSTEM = 5'b11100,
        OTHER     = 5'b11111
    } opcode_e;

    // Bit 3 marks a store, bits 2:0 are funct3.
    typedef enum logic [3:0] {
        MEM_LB  = 4'b0000,
        MEM_LH  = 4'b0001,
        MEM_LW  = 4'b0010,
        MEM_LBU = 4'b0100,
        MEM_LHU = 4'b0101,
        MEM_SB  = 4'b1000,
        MEM_SH  = 4'b1001,
        MEM_SW  = 4'b1010
    } memop_e;

    typedef enum logic [1:0] {
        CSR_NONE = 2'd0,
        CSR_RW   = 2'd1,
        CSR_RS   = 2'd2,
        CSR_RC   = 2'd3
    } csr_op_e;

    typedef enum logic [11:0] {
        MSTATUS = 12'h300,
        MTVEC   = 12'h305,
        MEPC    = 12'h341,
        MCAUSE  = 12'h342
    } csr_addr_e;

    typedef struct packed {
        logic            wren;
        logic            rden;
        memop_e          memop;
        logic [XLEN-1:0] wr_data;
    } mem_req_t;

    typedef enum logic [1:0] {
        IDLE,
        BUS,
        DONE
    } lsu_state_e;

    // Maps bits 6:2 of an instruction onto the known opcodes.
    function automatic opcode_e decode_op(input logic [4:0] field);
        case (field)
            OP_LOAD, OP_ALUI, OP_STORE, OP_ALU, OP_SYSTEM: return opcode_e'(field);
            default: return OTHER;
        endcase
    endfunction

endpackage

// File: wb_if.sv
`timescale 1ns/1ps

interface wb_if import ls_pkg::*; ();

    logic            cyc;
    logic            stb;
    logic            we;
    logic [XLEN-1:0] adr;
    logic [XLEN-1:0] dat_w;
    logic [XLEN-1:0] dat_r;
    logic [3:0]      sel;
    logic            ack;

    modport master (
        output cyc, stb, we, adr, dat_w, sel,
        input  dat_r, ack
    );

    modport slave (
        input  cyc, stb, we, adr, dat_w, sel,
        output dat_r, ack
    );

    modport monitor (
        input cyc, stb, we, adr, dat_w, dat_r, sel, ack
    );

endinterface

// File: ls_ctr.sv
`timescale 1ns/1ps

module ls_ctr import ls_pkg::*; (
    input  logic [INST_LEN-1:0] instr_i,
    input  logic [INST_LEN-1:0] instr_last_i,
    input  logic [XLEN-1:0]     rs2_i,
    input  logic [XLEN-1:0]     wb_data_i,
    output mem_req_t            req_o
);

    opcode_e    op;
    opcode_e    op_last;
    logic [4:0] rs2_idx;
    logic [4:0] rd_last;
    logic       last_writes_rd;
    logic       fwd;
    logic       is_store;
    logic       is_load;

    assign op      = decode_op(instr_i[6:2]);
    assign op_last = decode_op(instr_last_i[6:2]);
    assign rs2_idx = instr_i[24:20];
    assign rd_last = instr_last_i[11:7];

    assign is_store = (op == OP_STORE);
    assign is_load  = (op == OP_LOAD);

    // Previous instruction still sits in write-back.
    assign last_writes_rd = (op_last == OP_LOAD) || (op_last == OP_ALU) ||
                            (op_last == OP_ALUI);
    assign fwd = last_writes_rd && (rd_last != 5'd0) && (rd_last == rs2_idx);

    always_comb begin
        req_o.wren    = is_store;
        req_o.rden    = is_load;
        req_o.memop   = memop_e'({is_store, instr_i[14:12]});
        req_o.wr_data = fwd ? wb_data_i : rs2_i; // Bypass the register file.
    end

endmodule

// File: lsu.sv
`timescale 1ns/1ps

module lsu import ls_pkg::*; (
    input  logic            clk,
    input  logic            reset_i,
    input  mem_req_t        req_i,
    input  logic [XLEN-1:0] addr_i,
    output logic [XLEN-1:0] ls_res_o,
    output logic            ls_not_ok_o,
    wb_if.master            bus
);

    lsu_state_e      state_q;
    lsu_state_e      state_d;
    logic            req_valid;
    logic            active;
    logic [4:0]      lane_shift;
    logic [XLEN-1:0] rd_lane;
    logic [XLEN-1:0] load_val;
    logic [XLEN-1:0] ls_res_q;

    assign req_valid  = req_i.wren | req_i.rden;
    assign lane_shift = {addr_i[1:0], 3'b000};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bus FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    if (req_valid) state_d = BUS;
            BUS:     if (bus.ack) state_d = DONE;
            DONE:    state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    // Request goes out straight from IDLE, no setup cycle.
    assign active = ((state_q == IDLE) && req_valid) || (state_q == BUS);

    assign bus.cyc   = active;
    assign bus.stb   = active;
    assign bus.we    = req_i.wren;
    assign bus.adr   = {addr_i[XLEN-1:2], 2'b00};        // Word aligned.
    assign bus.dat_w = req_i.wr_data << lane_shift;

    always_comb begin
        case (req_i.memop)
            MEM_LB, MEM_LBU, MEM_SB: bus.sel = 4'b0001 << addr_i[1:0];
            MEM_LH, MEM_LHU, MEM_SH: bus.sel = 4'b0011 << {addr_i[1], 1'b0};
            default:                 bus.sel = 4'b1111;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read data extraction
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign rd_lane = bus.dat_r >> lane_shift;

    always_comb begin
        case (req_i.memop)
            MEM_LB:  load_val = {{(XLEN-8){rd_lane[7]}}, rd_lane[7:0]};
            MEM_LBU: load_val = {{(XLEN-8){1'b0}}, rd_lane[7:0]};
            MEM_LH:  load_val = {{(XLEN-16){rd_lane[15]}}, rd_lane[15:0]};
            MEM_LHU: load_val = {{(XLEN-16){1'b0}}, rd_lane[15:0]};
            default: load_val = rd_lane;
        endcase
    end

    always_ff @(posedge clk) begin
        if ((state_q == BUS) && bus.ack) begin
            ls_res_q <= req_i.rden ? load_val : '0; // Stores report zero.
        end
    end

    assign ls_res_o    = ls_res_q;
    assign ls_not_ok_o = active;

endmodule

// File: csr_unit.sv
`timescale 1ns/1ps

module csr_unit import ls_pkg::*; (
    input  logic                clk,
    input  logic                reset_i,
    input  logic [XLEN-1:0]     pc_i,
    input  logic [INST_LEN-1:0] instr_i,
    input  logic [XLEN-1:0]     csr_wr_data_i,
    input  logic                trap_i,
    input  logic                stall_n_i,
    output logic [XLEN-1:0]     csr_data_o,
    output logic [XLEN-1:0]     mtvec_o,
    output logic [XLEN-1:0]     mepc_o
);

    csr_op_e         csr_op;
    csr_addr_e       csr_addr;
    logic [XLEN-1:0] mstatus_q;
    logic [XLEN-1:0] mtvec_q;
    logic [XLEN-1:0] mepc_q;
    logic [XLEN-1:0] mcause_q;
    logic [XLEN-1:0] old_val;
    logic [XLEN-1:0] new_val;

    assign csr_addr = csr_addr_e'(instr_i[31:20]);

    always_comb begin
        csr_op = CSR_NONE;
        if (decode_op(instr_i[6:2]) == OP_SYSTEM) begin
            case (instr_i[14:12])
                3'd1:    csr_op = CSR_RW;
                3'd2:    csr_op = CSR_RS;
                3'd3:    csr_op = CSR_RC;
                default: csr_op = CSR_NONE;
            endcase
        end
    end

    always_comb begin
        case (csr_addr)
            MSTATUS: old_val = mstatus_q;
            MTVEC:   old_val = mtvec_q;
            MEPC:    old_val = mepc_q;
            MCAUSE:  old_val = mcause_q;
            default: old_val = '0;                // Unknown CSR reads zero.
        endcase
    end

    always_comb begin
        case (csr_op)
            CSR_RW:  new_val = csr_wr_data_i;
            CSR_RS:  new_val = old_val | csr_wr_data_i;
            CSR_RC:  new_val = old_val & ~csr_wr_data_i;
            default: new_val = old_val;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            mstatus_q <= '0;
            mtvec_q   <= '0;
            mepc_q    <= '0;
            mcause_q  <= '0;
        end else if (stall_n_i) begin
            if (trap_i) begin
                mepc_q   <= pc_i;
                mcause_q <= MCAUSE_LS_TRAP;
            end else if (csr_op != CSR_NONE) begin
                case (csr_addr)
                    MSTATUS: mstatus_q <= new_val;
                    MTVEC:   mtvec_q   <= new_val;
                    MEPC:    mepc_q    <= new_val;
                    MCAUSE:  mcause_q  <= new_val;
                    default: ;
                endcase
            end
        end
    end

    assign csr_data_o = old_val;
    assign mtvec_o    = mtvec_q;
    assign mepc_o     = mepc_q;

endmodule

// File: wb_arbiter.sv
`timescale 1ns/1ps

module wb_arbiter import ls_pkg::*; (
    input  logic clk,
    input  logic reset_i,
    wb_if.slave  m0,
    wb_if.slave  m1,
    wb_if.master s
);

    typedef enum logic [1:0] {
        OWN_NONE,
        OWN_M0,
        OWN_M1
    } owner_e;

    owner_e owner_q;
    owner_e grant;

    // Owner keeps the bus while its cycle lasts, then m0 wins.
    always_comb begin
        if ((owner_q == OWN_M0) && m0.cyc) begin
            grant = OWN_M0;
        end else if ((owner_q == OWN_M1) && m1.cyc) begin
            grant = OWN_M1;
        end else if (m0.cyc) begin
            grant = OWN_M0;
        end else if (m1.cyc) begin
            grant = OWN_M1;
        end else begin
            grant = OWN_NONE;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            owner_q <= OWN_NONE;
        end else begin
            owner_q <= grant;
        end
    end

    always_comb begin
        s.cyc   = 1'b0;
        s.stb   = 1'b0;
        s.we    = 1'b0;
        s.adr   = '0;
        s.dat_w = '0;
        s.sel   = '0;
        case (grant)
            OWN_M0: begin
                s.cyc   = m0.cyc;
                s.stb   = m0.stb;
                s.we    = m0.we;
                s.adr   = m0.adr;
                s.dat_w = m0.dat_w;
                s.sel   = m0.sel;
            end
            OWN_M1: begin
                s.cyc   = m1.cyc;
                s.stb   = m1.stb;
                s.we    = m1.we;
                s.adr   = m1.adr;
                s.dat_w = m1.dat_w;
                s.sel   = m1.sel;
            end
            default: ;
        endcase
    end

    assign m0.ack   = s.ack && (grant == OWN_M0);
    assign m1.ack   = s.ack && (grant == OWN_M1); // Waiting master sees no ack.
    assign m0.dat_r = (grant == OWN_M0) ? s.dat_r : '0;
    assign m1.dat_r = (grant == OWN_M1) ? s.dat_r : '0;

endmodule

// File: data_ram.sv
`timescale 1ns/1ps

module data_ram import ls_pkg::*; (
    input  logic clk,
    input  logic reset_i,
    wb_if.slave  bus
);

    logic [XLEN-1:0]              mem [RAM_WORDS];
    logic [$clog2(RAM_WORDS)-1:0] idx;
    logic                         access;
    logic                         ack_q;
    logic [XLEN-1:0]              dat_q;

    assign idx    = bus.adr[$clog2(RAM_WORDS)+1:2];
    assign access = bus.cyc && bus.stb && !ack_q; // One access per request.

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            if (bus.we) begin
                for (int i = 0; i < 4; i++) begin
                    if (bus.sel[i]) begin
                        mem[idx][8*i +: 8] <= bus.dat_w[8*i +: 8];
                    end
                end
            end
            dat_q <= mem[idx];
        end
    end

    assign bus.ack   = ack_q;
    assign bus.dat_r = dat_q;

endmodule

// File: ls_stage.sv
`timescale 1ns/1ps

module ls_stage import ls_pkg::*; (
    input  logic                clk,
    input  logic                reset_i,
    input  logic [XLEN-1:0]     pc_i,
    input  logic [XLEN-1:0]     alures_i,
    input  logic [XLEN-1:0]     rs2_i,
    input  logic [INST_LEN-1:0] instr_i,
    input  logic [INST_LEN-1:0] instr_last_i,
    input  logic [XLEN-1:0]     wb_data_i,
    input  logic                trap_ls_i,
    input  logic                stall_n_i,
    output logic [XLEN-1:0]     ls_res_o,
    output logic [XLEN-1:0]     csr_data_o,
    output logic [XLEN-1:0]     mtvec_o,
    output logic [XLEN-1:0]     mepc_o,
    output logic                ls_not_ok_o,
    input  logic                fetch_cyc_i,
    input  logic                fetch_stb_i,
    input  logic [XLEN-1:0]     fetch_adr_i,
    output logic [XLEN-1:0]     fetch_dat_o,
    output logic                fetch_ack_o
);

    mem_req_t req;

    wb_if lsu_bus ();
    wb_if fetch_bus ();
    wb_if ram_bus ();

    // Fetch side only ever reads whole words.
    assign fetch_bus.cyc   = fetch_cyc_i;
    assign fetch_bus.stb   = fetch_stb_i;
    assign fetch_bus.we    = 1'b0;
    assign fetch_bus.adr   = fetch_adr_i;
    assign fetch_bus.dat_w = '0;
    assign fetch_bus.sel   = 4'b1111;
    assign fetch_dat_o     = fetch_bus.dat_r;
    assign fetch_ack_o     = fetch_bus.ack;

    ls_ctr u_ls_ctr (
        .instr_i      (instr_i),
        .instr_last_i (instr_last_i),
        .rs2_i        (rs2_i),
        .wb_data_i    (wb_data_i),
        .req_o        (req)
    );

    lsu u_lsu (
        .clk         (clk),
        .reset_i     (reset_i),
        .req_i       (req),
        .addr_i      (alures_i),
        .ls_res_o    (ls_res_o),
        .ls_not_ok_o (ls_not_ok_o),
        .bus         (lsu_bus)
    );

    csr_unit u_csr_unit (
        .clk           (clk),
        .reset_i       (reset_i),
        .pc_i          (pc_i),
        .instr_i       (instr_i),
        .csr_wr_data_i (alures_i),                // ALU result carries rs1 or zimm.
        .trap_i        (trap_ls_i),
        .stall_n_i     (stall_n_i),
        .csr_data_o    (csr_data_o),
        .mtvec_o       (mtvec_o),
        .mepc_o        (mepc_o)
    );

    wb_arbiter u_wb_arbiter (
        .clk     (clk),
        .reset_i (reset_i),
        .m0      (lsu_bus),
        .m1      (fetch_bus),
        .s       (ram_bus)
    );

    data_ram u_data_ram (
        .clk     (clk),
        .reset_i (reset_i),
        .bus     (ram_bus)
    );

endmodule

// File: tb_ls_stage.sv
`timescale 1ns/1ps

module tb_ls_stage import ls_pkg::*; ();

    localparam logic [INST_LEN-1:0] NOP = 32'h0000_0013; // addi x0, x0, 0.
    localparam int WAIT_LIMIT = 50;

    logic                clk;
    logic                reset_i;
    logic [XLEN-1:0]     pc_i;
    logic [XLEN-1:0]     alures_i;
    logic [XLEN-1:0]     rs2_i;
    logic [INST_LEN-1:0] instr_i;
    logic [INST_LEN-1:0] instr_last_i;
    logic [XLEN-1:0]     wb_data_i;
    logic                trap_ls_i;
    logic                stall_n_i;
    logic [XLEN-1:0]     ls_res_o;
    logic [XLEN-1:0]     csr_data_o;
    logic [XLEN-1:0]     mtvec_o;
    logic [XLEN-1:0]     mepc_o;
    logic                ls_not_ok_o;
    logic                fetch_cyc_i;
    logic                fetch_stb_i;
    logic [XLEN-1:0]     fetch_adr_i;
    logic [XLEN-1:0]     fetch_dat_o;
    logic                fetch_ack_o;

    logic [XLEN-1:0] shadow [int];                  // Words written through the LSU.
    int              written [$];
    int              seed = 32'h5f644e7f;

    ls_stage UUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input logic [XLEN-1:0] exp,
                              input logic [XLEN-1:0] act);
        if (act !== exp) begin
            fail_now($sformatf("CHECK FAILED %s expected %08h actual %08h", name, exp, act));
        end
    endtask

    task automatic check_csr(input string name, input csr_addr_e addr,
                             input logic [XLEN-1:0] exp);
        if (csr_data_o !== exp) begin
            fail_now($sformatf("CHECK FAILED %s csr %03h expected %08h actual %08h",
                               name, addr, exp, csr_data_o));
        end
    endtask

    task automatic drive_idle();
        instr_i      = NOP;
        instr_last_i = NOP;
        pc_i         = '0;
        alures_i     = '0;
        rs2_i        = '0;
        wb_data_i    = '0;
        trap_ls_i    = 1'b0;
        stall_n_i    = 1'b1;
        fetch_cyc_i  = 1'b0;
        fetch_stb_i  = 1'b0;
        fetch_adr_i  = '0;
    endtask

    // Store data after the write-back bypass rule.
    function automatic logic [XLEN-1:0] store_value(input logic [INST_LEN-1:0] ins,
            input logic [INST_LEN-1:0] last, input logic [XLEN-1:0] rs2,
            input logic [XLEN-1:0] wb);
        logic [4:0] op_last;
        op_last = last[6:2];
        if ((op_last == 5'b00000 || op_last == 5'b01100 || op_last == 5'b00100) &&
            last[11:7] != 5'd0 && last[11:7] == ins[24:20]) begin
            return wb;
        end
        return rs2;
    endfunction

    // Byte-lane merge of a store into the shadow memory.
    task automatic record_store(input logic [INST_LEN-1:0] ins, input logic [XLEN-1:0] addr,
                                input logic [XLEN-1:0] data);
        int              w;
        int              lanes;
        logic [XLEN-1:0] word;
        w     = int'(addr[XLEN-1:2]);
        lanes = (ins[13:12] == 2'd0) ? 1 : ((ins[13:12] == 2'd1) ? 2 : 4);
        word  = shadow.exists(w) ? shadow[w] : '0;
        for (int i = 0; i < lanes; i++) begin
            word[8*(addr[1:0] + i) +: 8] = data[8*i +: 8];
        end
        if (!shadow.exists(w)) begin
            written.push_back(w);
        end
        shadow[w] = word;
    endtask

    function automatic logic [XLEN-1:0] csr_next(input logic [2:0] f3,
            input logic [XLEN-1:0] old, input logic [XLEN-1:0] data);
        case (f3)
            3'd1:    return data;
            3'd2:    return old | data;
            3'd3:    return old & ~data;
            default: return old;
        endcase
    endfunction

    task automatic wait_ls_done(input string name, input bit no_fetch_ack);
        bit done;
        done = 1'b0;
        for (int n = 0; n < WAIT_LIMIT && !done; n++) begin
            @(negedge clk);
            if (no_fetch_ack && fetch_ack_o && ls_not_ok_o) begin
                fail_now($sformatf("%s: fetch acknowledged while the load was busy", name));
            end
            done = !ls_not_ok_o;
        end
        if (!done) begin
            fail_now($sformatf("%s: load/store never finished", name));
        end
    endtask

    task automatic wait_fetch_ack(input string name);
        bit done;
        done = fetch_ack_o;
        for (int n = 0; n < WAIT_LIMIT && !done; n++) begin
            @(negedge clk);
            done = fetch_ack_o;
        end
        if (!done) begin
            fail_now($sformatf("%s: fetch port never acknowledged", name));
        end
    endtask

    task automatic run_fetch(input string name, input logic [XLEN-1:0] addr,
                             input logic [XLEN-1:0] exp);
        fetch_cyc_i = 1'b1;
        fetch_stb_i = 1'b1;
        fetch_adr_i = addr;
        @(negedge clk);
        wait_fetch_ack(name);
        check_data(name, exp, fetch_dat_o);
        drive_idle();
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Vector loop
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        int              fd;
        int              cnt;
        int              line_no;
        string           line;
        string           name;
        logic [8*8-1:0]  kind;
        logic [XLEN-1:0] f_instr, f_last, f_alu, f_rs2, f_wb, f_pc, f_exp;
        logic [XLEN-1:0] nv;
        csr_addr_e       addr;

        reset_i = 1'b1;
        drive_idle();
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;

        fd = $fopen("ls_stim.txt", "r");
        if (fd == 0) begin
            fail_now("cannot open the stimulus file ls_stim.txt");
        end
        line_no = 0;
        while (!$feof(fd)) begin
            line = "";
            cnt  = $fgets(line, fd);
            line_no++;
            if (line.len() < 2 || line[0] == "#") continue;
            cnt = $sscanf(line, "%s %h %h %h %h %h %h %h", kind, f_instr, f_last, f_alu,
                          f_rs2, f_wb, f_pc, f_exp);
            if (cnt != 8) begin
                fail_now($sformatf("malformed stimulus line %0d", line_no));
            end
            name = $sformatf("line %0d", line_no);
            drive_idle();
            @(negedge clk);
            if (kind == "LS" || kind == "RACE") begin
                instr_i      = f_instr;
                instr_last_i = f_last;
                alures_i     = f_alu;
                rs2_i        = f_rs2;
                wb_data_i    = f_wb;
                if (kind == "RACE") begin
                    fetch_cyc_i = 1'b1;                  // Same cycle as the load.
                    fetch_stb_i = 1'b1;
                    fetch_adr_i = f_pc;
                end
                #1;
                if (!ls_not_ok_o) begin
                    fail_now($sformatf("%s: ls_not_ok_o did not rise", name));
                end
                if (f_instr[6:2] == 5'b01000) begin
                    record_store(f_instr, f_alu, store_value(f_instr, f_last, f_rs2, f_wb));
                end
                wait_ls_done(name, kind == "RACE");
                check_data(name, f_exp, ls_res_o);
                instr_i = NOP;
                if (kind == "RACE") begin
                    wait_fetch_ack({name, " fetch"});
                    check_data({name, " fetch"}, f_wb, fetch_dat_o);
                end
            end else if (kind == "CSR" || kind == "STALL") begin
                instr_i   = f_instr;
                alures_i  = f_alu;
                stall_n_i = (kind == "CSR");
                addr      = csr_addr_e'(f_instr[31:20]);
                #1;
                check_csr(name, addr, f_exp);
                nv = (kind == "CSR") ? csr_next(f_instr[14:12], f_exp, f_alu) : f_exp;
                @(negedge clk);
                if (addr == MTVEC) check_data({name, " mtvec"}, nv, mtvec_o);
                if (addr == MEPC) check_data({name, " mepc"}, nv, mepc_o);
            end else if (kind == "TRAP") begin
                trap_ls_i = 1'b1;
                pc_i      = f_pc;
                @(negedge clk);
                trap_ls_i = 1'b0;
                check_data(name, f_exp, mepc_o);
            end else if (kind == "FETCH") begin
                run_fetch(name, f_alu, f_exp);
            end else begin
                fail_now($sformatf("unknown vector kind on line %0d", line_no));
            end
        end
        $fclose(fd);

        // Random fetches over words the LSU has written.
        for (int i = 0; i < 8; i++) begin
            int pick;
            pick = $unsigned($random(seed)) % written.size();
            drive_idle();
            @(negedge clk);
            run_fetch($sformatf("random fetch %0d", i), written[pick] << 2,
                      shadow[written[pick]]);
        end

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// File: ls_stim.txt
# kind instr instr_last alures rs2 wb_data pc expected (hex)
# RACE: pc is the fetch address, wb_data the expected fetch word
LS 0020A023 00000013 00000100 11223344 00000000 00000000 00000000
LS 0000A183 00000013 00000100 00000000 00000000 00000000 11223344
LS 00209023 00000013 00000102 0000ABCD 00000000 00000000 00000000
LS 0000A183 00000013 00000100 00000000 00000000 00000000 ABCD3344
LS 00009183 00000013 00000102 00000000 00000000 00000000 FFFFABCD
LS 0000D183 00000013 00000102 00000000 00000000 00000000 0000ABCD
LS 00009183 00000013 00000100 00000000 00000000 00000000 00003344
LS 00208023 00000013 00000101 000000F0 00000000 00000000 00000000
LS 00008183 00000013 00000101 00000000 00000000 00000000 FFFFFFF0
LS 0000C183 00000013 00000101 00000000 00000000 00000000 000000F0
LS 00008183 00000013 00000100 00000000 00000000 00000000 00000044
LS 00208023 00000013 00000103 00000080 00000000 00000000 00000000
LS 0000A183 00000013 00000100 00000000 00000000 00000000 80CDF044
LS 0020A023 00000013 00000200 DEADBEEF 00000000 00000000 00000000
LS 00208023 00000013 00000202 12345677 00000000 00000000 00000000
LS 0000C183 00000013 00000202 00000000 00000000 00000000 00000077
LS 0000A183 00000013 00000200 00000000 00000000 00000000 DE77BEEF
LS 0020A023 00000133 00000204 0BADF00D CAFE0001 00000000 00000000
LS 0000A183 00000013 00000204 00000000 00000000 00000000 CAFE0001
LS 0020A023 000002B3 00000208 13572468 99999999 00000000 00000000
LS 0000A183 00000013 00000208 00000000 00000000 00000000 13572468
CSR 30509073 00000013 00000400 00000000 00000000 00000000 00000000
CSR 30509073 00000013 00000800 00000000 00000000 00000000 00000400
CSR 34109073 00000013 00000123 00000000 00000000 00000000 00000000
CSR 3000A073 00000013 00000088 00000000 00000000 00000000 00000000
CSR 3000A073 00000013 00000003 00000000 00000000 00000000 00000088
CSR 3000B073 00000013 00000008 00000000 00000000 00000000 0000008B
STALL 30509073 00000013 FFFFFFFF 00000000 00000000 00000000 00000800
CSR 3000A073 00000013 00000000 00000000 00000000 00000000 00000083
CSR 3050A073 00000013 00000000 00000000 00000000 00000000 00000800
TRAP 00000013 00000013 00000000 00000000 00000000 00000444 00000444
CSR 3420A073 00000013 00000000 00000000 00000000 00000000 00000005
CSR 3410A073 00000013 00000000 00000000 00000000 00000000 00000444
FETCH 00000013 00000013 00000100 00000000 00000000 00000000 80CDF044
FETCH 00000013 00000013 00000204 00000000 00000000 00000000 CAFE0001
RACE 0000A183 00000013 00000200 00000000 13572468 00000208 DE77BEEF

// File: project.f
ls_pkg.sv
wb_if.sv
ls_ctr.sv
lsu.sv
csr_unit.sv
wb_arbiter.sv
data_ram.sv
ls_stage.sv
tb_ls_stage.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_ls_stage -f project.f -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
if ! grep -q "Simulation completed successfully" sim.log; then
    exit 1
fi
